// ==== tb.f ====
+incdir+include
source/cramPkg.sv
source/loadDecoder.sv
source/diagSequencer.sv
source/cramSlice.sv
source/readbackAssembler.sv
source/cramLoader.sv
testbench/clockGen.sv
testbench/cramLoaderTb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module cramLoaderTb -Mdir obj_dir
	./obj_dir/VcramLoaderTb | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== include/loadTable.svh ====
// Load file stimulus table
`ifndef LOAD_TABLE_SVH
`define LOAD_TABLE_SVH

////////////////////
// Control words used by the table

localparam cramPkg::tCramWord WordA = 86'h12_3456_789A_BCDE_F012_3456;
localparam cramPkg::tCramWord WordB = 86'h2A_5A5A_C3C3_0FF0_1234_ABCD;
localparam cramPkg::tCramWord WordC = 86'h3F_FFFF_0000_1111_2222_3333;
localparam cramPkg::tCramWord WordD = 86'h05_DEAD_BEEF_CAFE_F00D_0246;
localparam cramPkg::tCramWord WordE = 86'h1C_7654_3210_0F1E_2D3C_4B5A;
// Words at 136 and 137 carry the version
localparam cramPkg::tCramWord VerHi = 86'h0A_1B2C_3D4E_5F60_7182_93A4;
localparam cramPkg::tCramWord VerLo = 86'h26_C5E7_09F8_1A2B_3C4D_5E6F;

function automatic tRow newRow(tRowKind kind);
  tRow r;
  r.kind = kind;
  r.textIdx = 0;
  r.nWords = 0;
  r.addr = '0;
  r.w0 = '0;
  r.w1 = '0;
  r.badSum = 1'b0;
  r.pend = 1'b0;
  r.flag = flagLoadDone;
  r.expBit = 1'b0;
  return r;
endfunction

function automatic void addLine(cramPkg::tCramAddr addr, int n, cramPkg::tCramWord w0,
                                cramPkg::tCramWord w1, logic bad);
  tRow r;
  r = newRow(rowLine);
  r.addr = addr;
  r.nWords = n;
  r.w0 = w0;
  r.w1 = w1;
  r.badSum = bad;
  rows.push_back(r);
endfunction

function automatic void addRaw(string text);
  tRow r;
  r = newRow(rowRaw);
  r.textIdx = rawText.size();
  rawText.push_back(text);
  rows.push_back(r);
endfunction

function automatic void addRead(cramPkg::tCramAddr addr, cramPkg::tCramWord w, logic pend);
  tRow r;
  r = newRow(pend ? rowRead : rowReadNow);
  r.addr = addr;
  r.w0 = w;
  r.pend = pend;
  rows.push_back(r);
endfunction

function automatic void addReq(cramPkg::tCramAddr addr);
  tRow r;
  r = newRow(rowReq);
  r.addr = addr;
  rows.push_back(r);
endfunction

function automatic void addFlag(tFlagSel sel, logic exp);
  tRow r;
  r = newRow(rowFlag);
  r.flag = sel;
  r.expBit = exp;
  rows.push_back(r);
endfunction

function automatic void buildTable();
  tRow r;
  // Two words then end of file
  addLine(7'o20, 2, WordA, WordB, 1'b0);
  addRaw("C ,,");
  addFlag(flagLoadDone, 1'b1);
  addRead(7'o20, WordA, 1'b0);
  addRead(7'o21, WordB, 1'b0);
  addFlag(flagCksum, 1'b0);
  addFlag(flagFormat, 1'b0);
  // Address zero continues at 22
  addLine(7'o0, 1, WordC, '0, 1'b0);
  addRaw("C ,,");
  addFlag(flagLoadDone, 1'b1);
  addRead(7'o22, WordC, 1'b0);
  // Bad checksum still writes
  addLine(7'o40, 1, WordD, '0, 1'b1);
  addRaw("C ,,");
  addFlag(flagCksum, 1'b1);
  addRead(7'o40, WordD, 1'b0);
  // Version words
  addLine(cramPkg::VersionAddrHi, 2, VerHi, VerLo, 1'b0);
  addRaw("C ,,");
  addFlag(flagLoadDone, 1'b1);
  addFlag(flagVersionValid, 1'b1);
  r = newRow(rowVersion);
  r.w0 = VerHi;
  r.w1 = VerLo;
  rows.push_back(r);
  // Comment whose text would be a full word at 20 if parsed
  addRaw("; C A,P,A,A,A,A,A,A,A");
  addFlag(flagFormat, 1'b0);
  addRead(7'o20, WordA, 1'b0);
  addRaw("Z 1,2,3");
  addFlag(flagFormat, 1'b1);
  // Read held off by a load in progress
  addLine(7'o21, 1, WordE, '0, 1'b0);
  addReq(7'o21);
  addRaw("C ,,");
  addRead(7'o21, WordE, 1'b1);
endfunction

`endif

// ==== testbench/cramLoaderTb.sv ====
// CRAM loader testbench
`timescale 1ns/100ps

module cramLoaderTb;

  localparam int CharLimit = 200;
  localparam int ReadLimit = 600;

  typedef enum {rowLine, rowRaw, rowReq, rowRead, rowReadNow, rowFlag, rowVersion} tRowKind;
  typedef enum {flagLoadDone, flagVersionValid, flagCksum, flagFormat} tFlagSel;
  typedef struct {
    tRowKind kind;
    int textIdx;
    int nWords;
    cramPkg::tCramAddr addr;
    cramPkg::tCramWord w0;
    cramPkg::tCramWord w1;
    logic badSum;
    logic pend;
    tFlagSel flag;
    logic expBit;
  } tRow;

  tRow rows[$];
  string rawText[$];

  logic clk;
  logic arstN;
  logic charReq;
  cramPkg::tLoadChar charData;
  logic rdReq;
  cramPkg::tCramAddr rdAddr;
  logic charAck;
  logic rdAck;
  cramPkg::tCramWord rdWord;
  logic loadDone;
  logic cksumError;
  logic formatError;
  logic versionValid;
  cramPkg::tVersion version;

  int passCount;
  int failCount;
  logic timedOut;

  `include "loadTable.svh"

  clockGen iClock (.clk(clk), .arstN(arstN));

  cramLoader i_dut (.*);

  ////////////////////
  // Compare tasks

  task automatic checkWord(string name, cramPkg::tCramWord got, cramPkg::tCramWord exp);
    if (got === exp) begin
      passCount++;
      $display("ok     t=%0t %s = %h", $time, name, got);
    end else begin
      failCount++;
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkBit(string name, logic got, logic exp);
    if (got === exp) begin
      passCount++;
      $display("ok     t=%0t %s = %b", $time, name, got);
    end else begin
      failCount++;
      $display("FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic checkVersion(string name, cramPkg::tVersion got, cramPkg::tVersion exp);
    if (got === exp) begin
      passCount++;
      $display("ok     t=%0t %s = %h", $time, name, got);
    end else begin
      failCount++;
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  ////////////////////
  // Load file encoding

  // Six fields in load order
  function automatic cramPkg::tLoadWord loadField(cramPkg::tCramWord w, int idx);
    case (idx)
      0: return w[64:79];
      1: return w[48:63];
      2: return w[32:47];
      3: return w[16:31];
      4: return w[0:15];
      default: return {10'b0, w[80:85]};
    endcase
  endfunction

  // Three 6-bit groups with 4 bits in the top one
  function automatic string encodeField(cramPkg::tLoadWord v);
    string s;
    logic [5:0] g;
    s = "";
    for (int i = 2; i >= 0; i--) begin
      g = 6'(v >> (6 * i));
      s = $sformatf("%s%c", s, (g < 6'd62) ? 8'o100 + g : {2'b0, g});
    end
    return s;
  endfunction

  function automatic string encodeLine(tRow r);
    string s;
    cramPkg::tLoadWord sum;
    cramPkg::tLoadWord f;
    sum = 16'(6 * r.nWords) + 16'(r.addr);
    s = {"C ", encodeField(16'(6 * r.nWords)), ",", encodeField(16'(r.addr)), ","};
    for (int i = 0; i < 6 * r.nWords; i++) begin
      f = loadField(i < 6 ? r.w0 : r.w1, i % 6);
      sum = sum + f;
      s = {s, encodeField(f), ","};
    end
    // Checksum field makes the line sum zero
    f = -sum + 16'(r.badSum);
    return {s, encodeField(f)};
  endfunction

  function automatic cramPkg::tVersion expectedVersion(cramPkg::tCramWord hi,
                                                       cramPkg::tCramWord lo);
    cramPkg::tVersion v;
    v.major = {hi[29:31], hi[33:35]};
    v.minor = hi[37:39];
    v.edit = {lo[29:31], lo[33:35], lo[37:39]};
    return v;
  endfunction

  ////////////////////
  // Handshakes

  task automatic sendChar(cramPkg::tLoadChar c);
    int n;
    @(posedge clk);
    charData <= c;
    charReq <= 1'b1;
    n = 0;
    while (!charAck && n < CharLimit) begin
      @(posedge clk);
      n++;
    end
    charReq <= 1'b0;
    if (!charAck) begin
      $display("Timeout: no charAck for character %o", c);
      timedOut = 1'b1;
    end else begin
      n = 0;
      while (charAck && n < CharLimit) begin
        @(posedge clk);
        n++;
      end
      if (charAck) begin
        $display("Timeout: charAck never dropped after character %o", c);
        timedOut = 1'b1;
      end
    end
  endtask

  task automatic sendText(string s);
    for (int i = 0; i < s.len() && !timedOut; i++) begin
      sendChar(7'(s[i]));
    end
    if (!timedOut) begin
      sendChar(cramPkg::CharLf);
    end
  endtask

  task automatic readWord(tRow r);
    int n;
    if (!r.pend) begin
      @(posedge clk);
      rdAddr <= r.addr;
      rdReq <= 1'b1;
    end
    n = 0;
    while (!rdAck && n < ReadLimit) begin
      @(posedge clk);
      n++;
    end
    if (!rdAck) begin
      $display("Timeout: no rdAck for read of address %o", r.addr);
      timedOut = 1'b1;
    end else begin
      checkWord($sformatf("rdWord[%o]", r.addr), rdWord, r.w0);
      if (r.pend) begin
        checkBit("loadDone at rdAck", loadDone, 1'b1);
      end
      rdReq <= 1'b0;
      n = 0;
      while (rdAck && n < ReadLimit) begin
        @(posedge clk);
        n++;
      end
      if (rdAck) begin
        $display("Timeout: rdAck never dropped after read of address %o", r.addr);
        timedOut = 1'b1;
      end
    end
  endtask

  function automatic logic flagValue(tFlagSel sel);
    case (sel)
      flagLoadDone: return loadDone;
      flagVersionValid: return versionValid;
      flagCksum: return cksumError;
      default: return formatError;
    endcase
  endfunction

  function automatic string flagName(tFlagSel sel);
    case (sel)
      flagLoadDone: return "loadDone";
      flagVersionValid: return "versionValid";
      flagCksum: return "cksumError";
      default: return "formatError";
    endcase
  endfunction

  // Bounded wait for the flag to reach its expected value
  task automatic checkFlag(tRow r);
    int n;
    n = 0;
    while (flagValue(r.flag) !== r.expBit && n < ReadLimit) begin
      @(posedge clk);
      n++;
    end
    checkBit(flagName(r.flag), flagValue(r.flag), r.expBit);
  endtask

  task automatic applyRow(tRow r);
    case (r.kind)
      rowLine: sendText(encodeLine(r));
      rowRaw: sendText(rawText[r.textIdx]);
      rowReq: begin
        @(posedge clk);
        rdAddr <= r.addr;
        rdReq <= 1'b1;
      end
      rowRead, rowReadNow: readWord(r);
      rowFlag: checkFlag(r);
      default: checkVersion("version", version, expectedVersion(r.w0, r.w1));
    endcase
  endtask

  initial begin
    int n;
    charReq = 1'b0;
    charData = '0;
    rdReq = 1'b0;
    rdAddr = '0;
    passCount = 0;
    failCount = 0;
    timedOut = 1'b0;
    buildTable();
    n = 0;
    while (arstN !== 1'b1 && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (arstN !== 1'b1) begin
      $display("Timeout: reset never released");
      timedOut = 1'b1;
    end
    for (int i = 0; i < rows.size() && !timedOut; i++) begin
      applyRow(rows[i]);
    end
    $display("Checks: %0d passed, %0d failed", passCount, failCount);
    if (failCount == 0 && !timedOut) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== testbench/clockGen.sv ====
// Testbench clock and reset
`timescale 1ns/100ps

module clockGen (
  output logic clk,
  output logic arstN
);

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Reset held for four rising edges
  initial begin
    arstN = 1'b0;
    repeat (4) @(posedge clk);
    arstN <= 1'b1;
  end

endmodule

// ==== source/cramLoader.sv ====
// CRAM microcode loader top
`timescale 1ns/100ps

module cramLoader (
  input  logic              clk,
  input  logic              arstN,
  input  logic              charReq,
  input  cramPkg::tLoadChar charData,
  input  logic              rdReq,
  input  cramPkg::tCramAddr rdAddr,
  output logic              charAck,
  output logic              rdAck,
  output cramPkg::tCramWord rdWord,
  output logic              loadDone,
  output logic              cksumError,
  output logic              formatError,
  output logic              versionValid,
  output cramPkg::tVersion  version
);

  // Decoder to sequencer
  logic wordValid;
  logic wordReady;
  logic endOfFile;
  cramPkg::tCramWord cramWord;
  cramPkg::tCramAddr cramAddr;

  // Diagnostic bus shared by slices and assembler
  cramPkg::tDiagFunc diagFunc;
  logic diagStrobe;
  cramPkg::tEbusWord ebusData;
  cramPkg::tSliceData sliceRead [cramPkg::SliceCount];

  loadDecoder iDecoder (.*);

  diagSequencer iSequencer (.*);

  for (genvar i = 0; i < cramPkg::SliceCount; i++) begin : gSlice
    cramSlice #(
      .sliceIndex(i)
    ) iSlice (
      .clk        (clk),
      .arstN      (arstN),
      .diagFunc   (diagFunc),
      .diagStrobe (diagStrobe),
      .ebusData   (ebusData),
      .sliceRead  (sliceRead[i])
    );
  end

  readbackAssembler iAssembler (.*);

endmodule

// ==== source/readbackAssembler.sv ====
// Readback word and version assembler
`timescale 1ns/100ps

module readbackAssembler (
  input  logic               clk,
  input  logic               arstN,
  input  cramPkg::tDiagFunc  diagFunc,
  input  logic               diagStrobe,
  input  cramPkg::tEbusWord  ebusData,
  input  cramPkg::tSliceData sliceRead [cramPkg::SliceCount],
  output cramPkg::tCramWord  rdWord,
  output cramPkg::tVersion   version
);

  logic [0:cramPkg::PaddedWidth-1] gathered;
  logic [cramPkg::StrobeCntWidth-1:0] strobeCnt;
  logic [cramPkg::TxnWidth-1:0] readIdx;
  logic [cramPkg::SliceCount-1:0] driveMask;
  logic readHit;
  logic firstStrobe;
  logic lastStrobe;
  cramPkg::tSliceData busOr;
  cramPkg::tCramAddr addrQ;

  assign firstStrobe = diagStrobe && strobeCnt == '0;
  assign lastStrobe = diagStrobe && strobeCnt == cramPkg::StrobeCntMax - 1'b1;
  assign rdWord = gathered[0:cramPkg::CramWidth-1];

  // Merge slice outputs and find which slice is being read
  always_comb begin
    busOr = '0;
    readHit = 1'b0;
    readIdx = '0;
    for (int i = 0; i < cramPkg::SliceCount; i++) begin
      busOr = busOr | sliceRead[i];
      driveMask[i] = |sliceRead[i];
      if (diagFunc == cramPkg::SliceReadFunc[i]) begin
        readHit = 1'b1;
        readIdx = 3'(i);
      end
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      strobeCnt <= '0;
      addrQ <= '0;
    end else begin
      strobeCnt <= diagStrobe ? strobeCnt + 1'b1 : '0;
      if (firstStrobe && diagFunc == cramPkg::diagfCramAdrRh) begin
        addrQ[cramPkg::AddrLoBits-1:0] <= ebusData[0:cramPkg::AddrLoBits-1];
      end
      if (firstStrobe && diagFunc == cramPkg::diagfCramAdrLh) begin
        addrQ[cramPkg::CramAddrWidth-1:cramPkg::AddrLoBits] <=
          ebusData[0:cramPkg::AddrHiBits-1];
      end
    end
  end

  // Slice 1 carries control-word bits 20-39, so bit 29 is busOr[9]
  always_ff @(posedge clk) begin
    if (lastStrobe && readHit) begin
      gathered[readIdx*cramPkg::SliceWidth +: cramPkg::SliceWidth] <= busOr;
    end
    if (lastStrobe && diagFunc == cramPkg::diagfCramRead1) begin
      if (addrQ == cramPkg::VersionAddrHi) begin
        version.major <= {busOr[9:11], busOr[13:15]};
        version.minor <= busOr[17:19];
      end
      if (addrQ == cramPkg::VersionAddrLo) begin
        version.edit <= {busOr[9:11], busOr[13:15], busOr[17:19]};
      end
    end
  end

  // Only the addressed slice may drive the read bus
  assert property (@(posedge clk) disable iff (!arstN) $onehot0(driveMask));

endmodule

// ==== source/cramSlice.sv ====
// One CRAM slice
`timescale 1ns/100ps

module cramSlice #(
  parameter int sliceIndex = 0
) (
  input  logic               clk,
  input  logic               arstN,
  input  cramPkg::tDiagFunc  diagFunc,
  input  logic               diagStrobe,
  input  cramPkg::tEbusWord  ebusData,
  output cramPkg::tSliceData sliceRead
);

  logic [0:cramPkg::SliceKeepBits[sliceIndex]-1] mem [cramPkg::CramDepth];
  logic [0:cramPkg::SliceKeepBits[sliceIndex]-1] dataQ;
  cramPkg::tCramAddr addrQ;
  cramPkg::tSliceData readVal;
  logic strobeQ;
  logic firstStrobe;
  logic readOn;

  // Functions take effect on the first strobe cycle
  assign firstStrobe = diagStrobe && !strobeQ;
  // Read data appears from the second strobe cycle
  assign readOn = diagStrobe && strobeQ && diagFunc == cramPkg::SliceReadFunc[sliceIndex];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      strobeQ <= 1'b0;
      addrQ <= '0;
    end else begin
      strobeQ <= diagStrobe;
      if (firstStrobe && diagFunc == cramPkg::diagfCramAdrRh) begin
        addrQ[cramPkg::AddrLoBits-1:0] <= ebusData[0:cramPkg::AddrLoBits-1];
      end
      if (firstStrobe && diagFunc == cramPkg::diagfCramAdrLh) begin
        addrQ[cramPkg::CramAddrWidth-1:cramPkg::AddrLoBits] <=
          ebusData[0:cramPkg::AddrHiBits-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (firstStrobe && diagFunc == cramPkg::SliceWriteFunc[sliceIndex]) begin
      mem[addrQ] <= ebusData[0:cramPkg::SliceKeepBits[sliceIndex]-1];
    end
    if (firstStrobe) begin
      dataQ <= mem[addrQ];
    end
  end

  // Narrow last slice returns left-justified
  always_comb begin
    readVal = '0;
    readVal[0:cramPkg::SliceKeepBits[sliceIndex]-1] = dataQ;
  end

  assign sliceRead = readOn ? readVal : '0;

endmodule

// ==== source/diagSequencer.sv ====
// Diagnostic function sequencer
`timescale 1ns/100ps

module diagSequencer (
  input  logic              clk,
  input  logic              arstN,
  input  logic              wordValid,
  input  cramPkg::tCramWord cramWord,
  input  cramPkg::tCramAddr cramAddr,
  input  logic              endOfFile,
  input  logic              rdReq,
  input  cramPkg::tCramAddr rdAddr,
  output logic              wordReady,
  output logic              rdAck,
  output cramPkg::tDiagFunc diagFunc,
  output logic              diagStrobe,
  output cramPkg::tEbusWord ebusData,
  output logic              loadDone,
  output logic              versionValid
);

  typedef enum logic [2:0] {sIdle, sWrite, sRead, sVersion, sRdAck} tSeqState;

  tSeqState state;
  logic [cramPkg::TxnWidth-1:0] txn;
  logic [cramPkg::TxnWidth-1:0] lastTxn;
  logic [cramPkg::TxnWidth-1:0] sliceNum;
  logic [cramPkg::StrobeCntWidth-1:0] cnt;
  logic busy;
  logic loadActive;
  logic takeWord;
  logic takeRead;
  cramPkg::tCramWord wordReg;
  cramPkg::tCramAddr opAddr;
  cramPkg::tCramAddr curAddr;
  logic [0:cramPkg::PaddedWidth-1] paddedWord;

  assign wordReady = state == sIdle;
  // Load words win, reads wait for the whole load
  assign takeWord = state == sIdle && wordValid;
  assign takeRead = state == sIdle && !wordValid && !loadActive && rdReq;
  assign busy = state == sWrite || state == sRead || state == sVersion;
  assign diagStrobe = busy && cnt != cramPkg::StrobeCntMax;
  assign lastTxn = state == sVersion ? cramPkg::VersionLastTxn : cramPkg::WriteLastTxn;
  assign paddedWord = {wordReg, {cramPkg::PadBits{1'b0}}};

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= sIdle;
      txn <= '0;
      cnt <= '0;
      rdAck <= 1'b0;
      loadDone <= 1'b0;
      versionValid <= 1'b0;
      loadActive <= 1'b0;
    end else begin
      case (state)
        sIdle: begin
          txn <= '0;
          cnt <= '0;
          if (takeWord && endOfFile) begin
            state <= sVersion;
          end else if (takeWord) begin
            state <= sWrite;
            loadActive <= 1'b1;
            loadDone <= 1'b0;
            versionValid <= 1'b0;
          end else if (takeRead) begin
            state <= sRead;
          end
        end
        sRdAck: begin
          if (!rdReq) begin
            rdAck <= 1'b0;
            state <= sIdle;
          end
        end
        default: begin
          if (cnt != cramPkg::StrobeCntMax) begin
            cnt <= cnt + 1'b1;
          end else if (txn != lastTxn) begin
            cnt <= '0;
            txn <= txn + 1'b1;
          end else if (state == sRead) begin
            rdAck <= 1'b1;
            state <= sRdAck;
          end else if (state == sVersion) begin
            loadDone <= 1'b1;
            versionValid <= 1'b1;
            loadActive <= 1'b0;
            state <= sIdle;
          end else begin
            state <= sIdle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (takeWord) begin
      wordReg <= cramWord;
      opAddr <= endOfFile ? cramPkg::VersionAddrHi : cramAddr;
    end else if (takeRead) begin
      opAddr <= rdAddr;
    end
  end

  ////////////////////
  // Transaction decode

  always_comb begin
    sliceNum = txn - 2'd2;
    curAddr = (state == sVersion && txn == 3'd3) ? cramPkg::VersionAddrLo : opAddr;
    diagFunc = cramPkg::diagfNone;
    ebusData = '0;
    if (busy) begin
      if (txn == 3'd0 || (state == sVersion && txn == 3'd3)) begin
        diagFunc = cramPkg::diagfCramAdrRh;
        ebusData[0:cramPkg::AddrLoBits-1] = curAddr[cramPkg::AddrLoBits-1:0];
      end else if (txn == 3'd1) begin
        diagFunc = cramPkg::diagfCramAdrLh;
        ebusData[0:cramPkg::AddrHiBits-1] =
          curAddr[cramPkg::CramAddrWidth-1:cramPkg::AddrLoBits];
      end else if (state == sVersion) begin
        diagFunc = cramPkg::diagfCramRead1;
      end else if (state == sRead) begin
        diagFunc = cramPkg::SliceReadFunc[sliceNum];
      end else begin
        // Slice data goes left-justified on the EBUS
        diagFunc = cramPkg::SliceWriteFunc[sliceNum];
        ebusData[0:cramPkg::SliceWidth-1] =
          paddedWord[sliceNum*cramPkg::SliceWidth +: cramPkg::SliceWidth];
      end
    end
  end

  assert property (@(posedge clk) disable iff (!arstN)
    diagStrobe && $past(diagStrobe) |-> $stable(diagFunc) && $stable(ebusData));

endmodule

// ==== source/loadDecoder.sv ====
// Load file decoder
`timescale 1ns/100ps

module loadDecoder (
  input  logic              clk,
  input  logic              arstN,
  input  logic              charReq,
  input  cramPkg::tLoadChar charData,
  input  logic              wordReady,
  output logic              charAck,
  output logic              wordValid,
  output cramPkg::tCramWord cramWord,
  output cramPkg::tCramAddr cramAddr,
  output logic              endOfFile,
  output logic              cksumError,
  output logic              formatError
);

  typedef enum logic [1:0] {psLineStart, psFields, psSkip} tParseState;

  tParseState state;
  cramPkg::tLoadWord field;
  cramPkg::tLoadWord sum;
  cramPkg::tLoadWord sumNext;
  cramPkg::tCramAddr nextAddr;
  logic [1:0] fieldNum;
  logic [cramPkg::SlotWidth-1:0] slot;
  logic wcZero;
  logic take;
  logic isComma;
  logic isLf;
  logic isBlank;
  logic dataClose;

  // Un-ASCIIize one character into a 6-bit group
  function automatic cramPkg::tLoadWord groupValue(cramPkg::tLoadChar ch);
    if (ch >= 7'o100 && ch <= 7'o175) begin
      return 16'(ch[5:0]);
    end
    return 16'(ch);
  endfunction

  // New character only once the previous word is gone
  assign take = charReq && !charAck && !wordValid;
  assign isComma = charData == cramPkg::CharComma;
  assign isLf = charData == cramPkg::CharLf;
  assign isBlank = charData == cramPkg::CharSpace || charData == cramPkg::CharCr;
  assign sumNext = sum + field;
  // Comma after address closes a data field
  assign dataClose = take && state == psFields && isComma && fieldNum == 2'd2;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= psLineStart;
      field <= '0;
      sum <= '0;
      fieldNum <= '0;
      slot <= '0;
      wcZero <= 1'b0;
      nextAddr <= '0;
      charAck <= 1'b0;
      wordValid <= 1'b0;
      endOfFile <= 1'b0;
      cksumError <= 1'b0;
      formatError <= 1'b0;
    end else begin
      if (wordValid && wordReady) begin
        wordValid <= 1'b0;
      end
      // Four-phase return to zero
      if (charAck && !charReq) begin
        charAck <= 1'b0;
      end
      if (take) begin
        charAck <= 1'b1;
        case (state)
          psLineStart: begin
            field <= '0;
            sum <= '0;
            fieldNum <= '0;
            slot <= '0;
            if (charData == cramPkg::CharCramRec) begin
              state <= psFields;
            end else if (charData == cramPkg::CharComment) begin
              state <= psSkip;
            end else if (!isLf && !isBlank) begin
              formatError <= 1'b1;
              state <= psSkip;
            end
          end
          psFields: begin
            if (isComma || isLf) begin
              field <= '0;
              sum <= sumNext;
              if (isLf) begin
                // Last field is the negated checksum
                state <= psLineStart;
                if (sumNext != '0) begin
                  cksumError <= 1'b1;
                end
                if (wcZero) begin
                  wordValid <= 1'b1;
                  endOfFile <= 1'b1;
                end
              end else if (fieldNum == 2'd0) begin
                wcZero <= field == '0;
                fieldNum <= 2'd1;
              end else if (fieldNum == 2'd1) begin
                // Zero address keeps counting from the last line
                if (field != '0) begin
                  nextAddr <= field[cramPkg::CramAddrWidth-1:0];
                end
                fieldNum <= 2'd2;
              end else if (slot == cramPkg::SlotLast) begin
                slot <= '0;
                wordValid <= 1'b1;
                endOfFile <= 1'b0;
                nextAddr <= nextAddr + 1'b1;
              end else begin
                slot <= slot + 1'b1;
              end
            end else if (!isBlank) begin
              field <= (field << 6) | groupValue(charData);
            end
          end
          default: begin
            // Comment or bad record runs to end of line
            if (isLf) begin
              state <= psLineStart;
            end
          end
        endcase
      end
    end
  end

  // Data words arrive as 64-79, 48-63, 32-47, 16-31, 00-15, 80-85
  always_ff @(posedge clk) begin
    if (dataClose) begin
      case (slot)
        3'd0: cramWord[64:79] <= field;
        3'd1: cramWord[48:63] <= field;
        3'd2: cramWord[32:47] <= field;
        3'd3: cramWord[16:31] <= field;
        3'd4: cramWord[0:15] <= field;
        default: cramWord[80:85] <= field[5:0];
      endcase
      if (slot == cramPkg::SlotLast) begin
        cramAddr <= nextAddr;
      end
    end
  end

  // Offered word holds until the sequencer takes it
  assert property (@(posedge clk) disable iff (!arstN)
    wordValid && !wordReady |=> wordValid && $stable(cramWord) && $stable(endOfFile));

endmodule

// ==== source/cramPkg.sv ====
// CRAM loader shared definitions

package cramPkg;

  ////////////////////
  // Sizes

  localparam int CramWidth = 86;
  localparam int SliceWidth = 20;
  localparam int SliceCount = 5;
  localparam int CramAddrWidth = 7;
  localparam int CramDepth = 128;
  localparam int EbusWidth = 36;
  localparam int WordsPerCram = 6;
  localparam int DiagStrobeCycles = 5;

  // Address travels as two diagnostic writes
  localparam int AddrLoBits = 2;
  localparam int AddrHiBits = CramAddrWidth - AddrLoBits;

  // Last slice holds CALL and DISP bits 80-85 only
  localparam int LastSliceBits = CramWidth - (SliceCount - 1) * SliceWidth;
  localparam int PaddedWidth = SliceCount * SliceWidth;
  localparam int PadBits = PaddedWidth - CramWidth;
  localparam int SliceKeepBits [SliceCount] =
    '{SliceWidth, SliceWidth, SliceWidth, SliceWidth, LastSliceBits};

  // Counters in the sequencer and decoder
  localparam int StrobeCntWidth = 3;
  localparam int TxnWidth = 3;
  localparam int SlotWidth = 3;
  localparam logic [StrobeCntWidth-1:0] StrobeCntMax = StrobeCntWidth'(DiagStrobeCycles);
  localparam logic [TxnWidth-1:0] WriteLastTxn = TxnWidth'(SliceCount + 1);
  localparam logic [TxnWidth-1:0] VersionLastTxn = TxnWidth'(4);
  localparam logic [SlotWidth-1:0] SlotLast = SlotWidth'(WordsPerCram - 1);

  ////////////////////
  // Types

  typedef logic [0:CramWidth-1] tCramWord;
  typedef logic [CramAddrWidth-1:0] tCramAddr;
  typedef logic [0:EbusWidth-1] tEbusWord;
  typedef logic [0:SliceWidth-1] tSliceData;
  typedef logic [15:0] tLoadWord;
  typedef logic [6:0] tLoadChar;

  // Diagnostic function codes seen on the EBUS
  typedef enum logic [6:0] {
    diagfNone       = 7'o000,
    diagfCramAdrRh  = 7'o051,
    diagfCramAdrLh  = 7'o052,
    diagfCramWrite4 = 7'o053,
    diagfCramWrite3 = 7'o054,
    diagfCramWrite2 = 7'o055,
    diagfCramWrite1 = 7'o056,
    diagfCramWrite0 = 7'o057,
    diagfCramRead4  = 7'o141,
    diagfCramRead3  = 7'o144,
    diagfCramRead2  = 7'o145,
    diagfCramRead1  = 7'o146,
    diagfCramRead0  = 7'o147
  } tDiagFunc;

  localparam tDiagFunc SliceWriteFunc [SliceCount] = '{diagfCramWrite0, diagfCramWrite1,
    diagfCramWrite2, diagfCramWrite3, diagfCramWrite4};
  localparam tDiagFunc SliceReadFunc [SliceCount] = '{diagfCramRead0, diagfCramRead1,
    diagfCramRead2, diagfCramRead3, diagfCramRead4};

  typedef struct packed {
    logic [5:0] major;
    logic [2:0] minor;
    logic [8:0] edit;
  } tVersion;

  // Microcode version lives in slice 1 of these words
  localparam tCramAddr VersionAddrHi = 7'o136;
  localparam tCramAddr VersionAddrLo = 7'o137;

  ////////////////////
  // Load file characters

  localparam tLoadChar CharComma = 7'o054;
  localparam tLoadChar CharLf = 7'o012;
  localparam tLoadChar CharCr = 7'o015;
  localparam tLoadChar CharSpace = 7'o040;
  localparam tLoadChar CharComment = 7'o073;
  localparam tLoadChar CharCramRec = 7'o103;

endpackage
